// File: logic/rvIsaPkg.sv
package rvIsaPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regName_t;
    typedef logic [2:0]  func3_t;
    typedef logic [6:0]  func7_t;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OPIMM  = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    // Field positions in an instruction word
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int FUNC3_LSB  = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNC7_LSB  = 25;

    localparam func3_t F3_ADD = 3'b000;
    localparam func3_t F3_SLT = 3'b010;
    localparam func3_t F3_XOR = 3'b100;
    localparam func3_t F3_OR  = 3'b110;
    localparam func3_t F3_AND = 3'b111;
    localparam func3_t F3_BNE = 3'b001;
    localparam func7_t FUNC7_ALT = 7'b0100000;

    localparam int    REG_COUNT = 32;
    localparam int    IM_DEPTH  = 256;
    localparam word_t PC_STEP   = 32'd4;
    // addi x0, x0, 0
    localparam word_t NOP = 32'h0000_0013;

endpackage

// File: logic/coreCtrlPkg.sv
package coreCtrlPkg;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_BRANCH,
        ALU_FUNCT
    } aluOp_t;

    typedef enum logic [1:0] {
        SRC1_REG,
        SRC1_UIMM,
        SRC1_PCFOUR
    } aluSrc1_t;

    typedef enum logic [1:0] {
        SRC2_REG,
        SRC2_IIMM,
        SRC2_SIMM,
        SRC2_PC
    } aluSrc2_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_FROMMEM,
        FWD_FROMWB
    } forwardSel_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        HALTED
    } runState_t;

endpackage

// File: logic/dataMemBus.sv
`timescale 1ns/1ns
interface dataMemBus;
    import rvIsaPkg::*;

    logic   memRead;
    logic   memWrite;
    func3_t func3;
    word_t  addr;
    word_t  writeData;
    word_t  readData;
    logic   memReady;

    modport master (
        output memRead, memWrite, func3, addr, writeData,
        input  readData, memReady
    );

    modport slave (
        input  memRead, memWrite, func3, addr, writeData,
        output readData, memReady
    );

endinterface

// File: logic/alu.sv
`timescale 1ns/1ns
module alu (
    input  coreCtrlPkg::aluOp_t aluOp,
    input  rvIsaPkg::func3_t    func3,
    input  rvIsaPkg::func7_t    func7,
    input  rvIsaPkg::word_t     a,
    input  rvIsaPkg::word_t     b,
    output rvIsaPkg::word_t     result,
    output logic                zero
);
    import rvIsaPkg::*;
    import coreCtrlPkg::*;

    always_comb begin
        case (aluOp)
            ALU_BRANCH: result = a - b;
            ALU_FUNCT: begin
                case (func3)
                    F3_ADD:  result = (func7 == FUNC7_ALT) ? a - b : a + b;
                    F3_SLT:  result = word_t'($signed(a) < $signed(b));
                    F3_XOR:  result = a ^ b;
                    F3_OR:   result = a | b;
                    F3_AND:  result = a & b;
                    default: result = a + b;
                endcase
            end
            // Address, immediate and link arithmetic
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: logic/registerFile.sv
`timescale 1ns/1ns
module registerFile (
    input  logic               clk,
    input  logic               reset,
    input  logic               writeEnable,
    input  rvIsaPkg::regName_t rs1,
    input  rvIsaPkg::regName_t rs2,
    input  rvIsaPkg::regName_t rd,
    input  rvIsaPkg::word_t    writeData,
    output rvIsaPkg::word_t    rs1Data,
    output rvIsaPkg::word_t    rs2Data
);
    import rvIsaPkg::*;

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && rd != '0) begin
            regs[rd] <= writeData;
        end
    end

    // WB write shows up in the same-cycle ID read
    assign rs1Data = (writeEnable && rd != '0 && rd == rs1) ? writeData : regs[rs1];
    assign rs2Data = (writeEnable && rd != '0 && rd == rs2) ? writeData : regs[rs2];

endmodule

// File: logic/hazardUnit.sv
`timescale 1ns/1ns
module hazardUnit (
    input  rvIsaPkg::regName_t       idRs1,
    input  rvIsaPkg::regName_t       idRs2,
    input  logic                     idUsesBranch,
    input  rvIsaPkg::regName_t       exRd,
    input  logic                     exMemRead,
    input  logic                     exRegWrite,
    input  rvIsaPkg::regName_t       exRs1,
    input  rvIsaPkg::regName_t       exRs2,
    input  rvIsaPkg::regName_t       memRd,
    input  logic                     memRegWrite,
    input  logic                     memAccess,
    input  logic                     memReady,
    input  rvIsaPkg::regName_t       wbRd,
    input  logic                     wbRegWrite,
    output logic                     stall,
    output logic                     freeze,
    output coreCtrlPkg::forwardSel_t forward1,
    output coreCtrlPkg::forwardSel_t forward2
);
    import rvIsaPkg::*;
    import coreCtrlPkg::*;

    logic loadUse;
    logic branchWait;

    // x0 never counts as a dependency
    function automatic logic writes(logic regWrite, regName_t rd, regName_t rs);
        return regWrite && rd != '0 && rd == rs;
    endfunction

    assign loadUse = writes(exMemRead, exRd, idRs1) || writes(exMemRead, exRd, idRs2);

    // Branches compare in ID, so wait for results still in EX or MEM
    assign branchWait = idUsesBranch
        && (writes(exRegWrite, exRd, idRs1) || writes(exRegWrite, exRd, idRs2)
        || writes(memRegWrite, memRd, idRs1) || writes(memRegWrite, memRd, idRs2));

    assign stall  = loadUse || branchWait;
    assign freeze = memAccess && !memReady;

    assign forward1 = writes(memRegWrite, memRd, exRs1) ? FWD_FROMMEM
                    : writes(wbRegWrite, wbRd, exRs1) ? FWD_FROMWB : FWD_NONE;
    assign forward2 = writes(memRegWrite, memRd, exRs2) ? FWD_FROMMEM
                    : writes(wbRegWrite, wbRd, exRs2) ? FWD_FROMWB : FWD_NONE;

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/1ns
module controlUnit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  startProcess,
    input  rvIsaPkg::word_t       instruction,
    output logic                  endProcess,
    output logic                  enable,
    output logic                  jump,
    output logic                  branch,
    output logic                  memRead,
    output logic                  memWrite,
    output logic                  memToReg,
    output logic                  regWrite,
    output coreCtrlPkg::aluSrc1_t aluSrc1,
    output coreCtrlPkg::aluSrc2_t aluSrc2,
    output coreCtrlPkg::aluOp_t   aluOp,
    output rvIsaPkg::word_t       immI,
    output rvIsaPkg::word_t       immS,
    output rvIsaPkg::word_t       immB,
    output rvIsaPkg::word_t       immU,
    output rvIsaPkg::word_t       immJ
);
    import rvIsaPkg::*;
    import coreCtrlPkg::*;

    runState_t state;
    runState_t nextState;
    opcode_t   opcode;

    assign opcode = opcode_t'(instruction[OPCODE_LSB +: $bits(opcode_t)]);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            IDLE:    nextState = startProcess ? RUN : IDLE;
            RUN:     nextState = (opcode == OPC_SYSTEM) ? HALTED : RUN;
            default: nextState = HALTED;
        endcase
    end

    assign enable     = (state == RUN);
    assign endProcess = (state == HALTED);

    always_comb begin
        jump     = 1'b0;
        branch   = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        regWrite = 1'b0;
        aluSrc1  = SRC1_REG;
        aluSrc2  = SRC2_REG;
        aluOp    = ALU_ADD;
        if (enable) begin
            case (opcode)
                OPC_OP: begin
                    regWrite = 1'b1;
                    aluOp    = ALU_FUNCT;
                end
                OPC_OPIMM: begin
                    regWrite = 1'b1;
                    aluSrc2  = SRC2_IIMM;
                end
                OPC_LUI: begin
                    regWrite = 1'b1;
                    aluSrc1  = SRC1_UIMM;
                end
                OPC_LOAD: begin
                    memRead  = 1'b1;
                    memToReg = 1'b1;
                    regWrite = 1'b1;
                    aluSrc2  = SRC2_IIMM;
                end
                OPC_STORE: begin
                    memWrite = 1'b1;
                    aluSrc2  = SRC2_SIMM;
                end
                OPC_BRANCH: begin
                    branch = 1'b1;
                    aluOp  = ALU_BRANCH;
                end
                OPC_JAL: begin
                    jump     = 1'b1;
                    regWrite = 1'b1;
                    aluSrc1  = SRC1_PCFOUR;
                    aluSrc2  = SRC2_PC;
                end
                // Halt and unknown opcodes go down the pipe as bubbles
                default: regWrite = 1'b0;
            endcase
        end
    end

    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign immU = {instruction[31:12], 12'b0};
    assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};

endmodule

// File: logic/processor.sv
`timescale 1ns/1ns
module processor (
    input  logic             clk,
    input  logic             reset,
    input  logic             startProcess,
    output logic             endProcess,
    output rvIsaPkg::word_t  pc,
    input  rvIsaPkg::word_t  instruction,
    dataMemBus.master        dataBus
);
    import rvIsaPkg::*;
    import coreCtrlPkg::*;

    // IF/ID bank and decode
    word_t    pcId;
    word_t    instrId;
    regName_t rs1Id;
    regName_t rs2Id;
    regName_t rdId;
    func3_t   func3Id;
    func7_t   func7Id;
    logic     enable, jumpId, branchId;
    logic     memReadId, memWriteId, memToRegId, regWriteId;
    aluSrc1_t aluSrc1Id;
    aluSrc2_t aluSrc2Id;
    aluOp_t   aluOpId;
    word_t    immI, immS, immB, immU, immJ;
    word_t    rs1DataId, rs2DataId;
    word_t    branchTarget;
    logic     zeroId, takeBranch, stall, freeze;

    // ID/EX bank
    word_t       pcEx, rs1DataEx, rs2DataEx, immIEx, immSEx, immUEx;
    regName_t    rs1Ex, rs2Ex, rdEx;
    func3_t      func3Ex;
    func7_t      func7Ex;
    aluSrc1_t    aluSrc1Ex;
    aluSrc2_t    aluSrc2Ex;
    aluOp_t      aluOpEx;
    logic        memReadEx, memWriteEx, memToRegEx, regWriteEx;
    forwardSel_t forward1, forward2;
    word_t       operand1, operand2, aluIn1, aluIn2, aluOutEx;

    // EX/MEM and MEM/WB banks
    word_t    aluOutMem, storeDataMem;
    regName_t rdMem;
    func3_t   func3Mem;
    logic     memReadMem, memWriteMem, memToRegMem, regWriteMem;
    word_t    aluOutWb, readDataWb, writeBackData;
    regName_t rdWb;
    logic     memToRegWb, regWriteWb;

    assign rdId    = instrId[RD_LSB +: $bits(regName_t)];
    assign rs1Id   = instrId[RS1_LSB +: $bits(regName_t)];
    assign func3Id = instrId[FUNC3_LSB +: $bits(func3_t)];
    assign func7Id = instrId[FUNC7_LSB +: $bits(func7_t)];
    // LUI keeps immediate bits in the rs2 field, so read x0 instead
    assign rs2Id = (aluSrc1Id == SRC1_UIMM) ? '0 : instrId[RS2_LSB +: $bits(regName_t)];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (!freeze && !stall && enable) begin
            pc <= takeBranch ? branchTarget : pc + PC_STEP;
        end
    end

    // Squash the fetched successor on a taken branch or outside RUN
    always_ff @(posedge clk) begin
        if (reset) begin
            instrId <= NOP;
        end else if (!freeze && !stall) begin
            instrId <= (enable && !takeBranch) ? instruction : NOP;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze && !stall) begin
            pcId <= pc;
        end
    end

    controlUnit u_controlUnit (
        .clk,
        .reset,
        .startProcess,
        .instruction(instrId),
        .endProcess,
        .enable,
        .jump(jumpId),
        .branch(branchId),
        .memRead(memReadId),
        .memWrite(memWriteId),
        .memToReg(memToRegId),
        .regWrite(regWriteId),
        .aluSrc1(aluSrc1Id),
        .aluSrc2(aluSrc2Id),
        .aluOp(aluOpId),
        .immI,
        .immS,
        .immB,
        .immU,
        .immJ
    );

    registerFile u_registerFile (
        .clk,
        .reset,
        .writeEnable(regWriteWb),
        .rs1(rs1Id),
        .rs2(rs2Id),
        .rd(rdWb),
        .writeData(writeBackData),
        .rs1Data(rs1DataId),
        .rs2Data(rs2DataId)
    );

    // Branch compare in ID
    alu u_branchAlu (
        .aluOp(ALU_BRANCH),
        .func3(func3Id),
        .func7(func7Id),
        .a(rs1DataId),
        .b(rs2DataId),
        .result(),
        .zero(zeroId)
    );

    assign takeBranch = !stall
        && (jumpId || (branchId && ((func3Id == F3_BNE) ? !zeroId : zeroId)));
    assign branchTarget = pcId + (jumpId ? immJ : immB);

    hazardUnit u_hazardUnit (
        .idRs1(rs1Id),
        .idRs2(rs2Id),
        .idUsesBranch(branchId),
        .exRd(rdEx),
        .exMemRead(memReadEx),
        .exRegWrite(regWriteEx),
        .exRs1(rs1Ex),
        .exRs2(rs2Ex),
        .memRd(rdMem),
        .memRegWrite(regWriteMem),
        .memAccess(memReadMem || memWriteMem),
        .memReady(dataBus.memReady),
        .wbRd(rdWb),
        .wbRegWrite(regWriteWb),
        .stall,
        .freeze,
        .forward1,
        .forward2
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            {memReadEx, memWriteEx, memToRegEx, regWriteEx} <= '0;
        end else if (!freeze) begin
            // A stall sends a bubble into EX
            {memReadEx, memWriteEx, memToRegEx, regWriteEx} <= stall ? '0
                : {memReadId, memWriteId, memToRegId, regWriteId};
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            pcEx      <= pcId;
            rs1DataEx <= rs1DataId;
            rs2DataEx <= rs2DataId;
            immIEx    <= immI;
            immSEx    <= immS;
            immUEx    <= immU;
            rs1Ex     <= rs1Id;
            rs2Ex     <= rs2Id;
            rdEx      <= rdId;
            func3Ex   <= func3Id;
            func7Ex   <= func7Id;
            aluSrc1Ex <= aluSrc1Id;
            aluSrc2Ex <= aluSrc2Id;
            aluOpEx   <= aluOpId;
        end
    end

    always_comb begin
        case (forward1)
            FWD_FROMMEM: operand1 = aluOutMem;
            FWD_FROMWB:  operand1 = writeBackData;
            default:     operand1 = rs1DataEx;
        endcase
        case (forward2)
            FWD_FROMMEM: operand2 = aluOutMem;
            FWD_FROMWB:  operand2 = writeBackData;
            default:     operand2 = rs2DataEx;
        endcase
    end

    always_comb begin
        case (aluSrc1Ex)
            SRC1_UIMM:   aluIn1 = immUEx;
            SRC1_PCFOUR: aluIn1 = PC_STEP;
            default:     aluIn1 = operand1;
        endcase
        case (aluSrc2Ex)
            SRC2_IIMM: aluIn2 = immIEx;
            SRC2_SIMM: aluIn2 = immSEx;
            SRC2_PC:   aluIn2 = pcEx;
            default:   aluIn2 = operand2;
        endcase
    end

    alu u_alu (
        .aluOp(aluOpEx),
        .func3(func3Ex),
        .func7(func7Ex),
        .a(aluIn1),
        .b(aluIn2),
        .result(aluOutEx),
        .zero()
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            {memReadMem, memWriteMem, memToRegMem, regWriteMem} <= '0;
        end else if (!freeze) begin
            {memReadMem, memWriteMem, memToRegMem, regWriteMem}
                <= {memReadEx, memWriteEx, memToRegEx, regWriteEx};
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            aluOutMem    <= aluOutEx;
            storeDataMem <= operand2;
            rdMem        <= rdEx;
            func3Mem     <= func3Ex;
        end
    end

    assign dataBus.memRead   = memReadMem;
    assign dataBus.memWrite  = memWriteMem;
    assign dataBus.func3     = func3Mem;
    assign dataBus.addr      = aluOutMem;
    assign dataBus.writeData = storeDataMem;

    always_ff @(posedge clk) begin
        if (reset) begin
            {memToRegWb, regWriteWb} <= '0;
        end else if (!freeze) begin
            {memToRegWb, regWriteWb} <= {memToRegMem, regWriteMem};
        end
    end

    // Load data is taken in the cycle the access completes
    always_ff @(posedge clk) begin
        if (!freeze) begin
            aluOutWb   <= aluOutMem;
            readDataWb <= dataBus.readData;
            rdWb       <= rdMem;
        end
    end

    assign writeBackData = memToRegWb ? readDataWb : aluOutWb;

endmodule

// File: logic/instructionMemory.sv
`timescale 1ns/1ns
module instructionMemory (
    input  rvIsaPkg::word_t pc,
    output rvIsaPkg::word_t instruction
);
    import rvIsaPkg::*;

    word_t rom [IM_DEPTH];
    word_t wordIndex;

    initial begin
        $readmemh("program.hex", rom);
    end

    assign wordIndex = pc / PC_STEP;

    // Fetches past the end of the ROM see a NOP
    assign instruction = (wordIndex < IM_DEPTH)
        ? rom[wordIndex[$clog2(IM_DEPTH)-1:0]] : NOP;

endmodule

// File: logic/cpuSystem.sv
`timescale 1ns/1ns
module cpuSystem (
    input  logic             clk,
    input  logic             reset,
    input  logic             startProcess,
    output logic             endProcess,
    output logic             memRead,
    output logic             memWrite,
    output rvIsaPkg::func3_t memFunc3,
    output rvIsaPkg::word_t  memAddr,
    output rvIsaPkg::word_t  memWriteData,
    input  rvIsaPkg::word_t  memReadData,
    input  logic             memReady
);
    import rvIsaPkg::*;

    word_t pc;
    word_t instruction;

    dataMemBus dataBus ();

    processor u_processor (
        .clk,
        .reset,
        .startProcess,
        .endProcess,
        .pc,
        .instruction,
        .dataBus(dataBus.master)
    );

    instructionMemory u_instructionMemory (
        .pc,
        .instruction
    );

    // Data memory lives outside, behind plain strobes
    assign memRead      = dataBus.memRead;
    assign memWrite     = dataBus.memWrite;
    assign memFunc3     = dataBus.func3;
    assign memAddr      = dataBus.addr;
    assign memWriteData = dataBus.writeData;

    assign dataBus.readData = memReadData;
    assign dataBus.memReady = memReady;

endmodule

// File: verif/cpuSystemTb.sv
`timescale 1ns/1ns
module cpuSystemTb;
    import rvIsaPkg::*;

    localparam int     STORE_TIMEOUT = 3000;
    localparam int     HALT_TIMEOUT  = 50;
    localparam int     QUIET_CYCLES  = 20;
    localparam int     MEM_WORDS     = 1024;
    localparam word_t  LOAD_ADDR     = 32'h0000_0100;
    localparam word_t  POISON_ADDR   = 32'h0000_03FC;
    localparam func3_t WORD_FUNC3    = 3'b010;

    logic   clk = 1'b0;
    logic   reset = 1'b1;
    logic   startProcess = 1'b0;
    logic   memReady = 1'b1;
    logic   endProcess;
    logic   memRead;
    logic   memWrite;
    func3_t memFunc3;
    word_t  memAddr;
    word_t  memWriteData;
    word_t  memReadData;

    word_t dataMem [MEM_WORDS];
    word_t expAddr [$];
    word_t expData [$];
    word_t loadValue;
    int    storeCount;
    int    waitLeft;
    logic  sawLoad;
    logic  started = 1'b0;
    logic  idleCheck = 1'b0;

    // Bus values from the previous cycle
    logic  prevRead;
    logic  prevWrite;
    logic  prevPending;
    word_t prevAddr;
    word_t prevWriteData;

    cpuSystem u_cpuSystem (
        .clk,
        .reset,
        .startProcess,
        .endProcess,
        .memRead,
        .memWrite,
        .memFunc3,
        .memAddr,
        .memWriteData,
        .memReadData,
        .memReady
    );

    always #50 clk = ~clk;

    assign memReadData = dataMem[memAddr[11:2]];

    task automatic reportMismatch(input string testName, input word_t expected,
                                  input word_t actual);
        $display("Fail %s expected %h actual %h", testName, expected, actual);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic reportProblem(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    // Expected stores in program order
    function automatic void buildExpected();
        word_t results [8];
        word_t sum;
        int    i;
        results[0] = 32'd100;
        results[1] = word_t'(-7);
        results[2] = results[0] + results[1];
        results[3] = results[2] - results[0];
        results[4] = results[3] & results[2];
        results[5] = results[4] | results[1];
        results[6] = results[5] ^ results[2];
        results[7] = ($signed(results[3]) < $signed(results[2])) ? 32'd1 : 32'd0;
        for (i = 0; i < 8; i++) begin
            expAddr.push_back(32'h200 + 4 * i);
            expData.push_back(results[i]);
        end
        expAddr.push_back(32'h300);
        expData.push_back(loadValue + 32'd7);
        sum = '0;
        for (i = 1; i <= 10; i++) begin
            sum = sum + i;
        end
        expAddr.push_back(32'h304);
        expData.push_back(sum);
        expAddr.push_back(32'h308);
        expData.push_back(32'h12345 << 12);
    endfunction

    // Data memory with a random ready delay per access
    always @(posedge clk) begin
        int delay;
        int i;
        if (reset) begin
            for (i = 0; i < MEM_WORDS; i++) begin
                dataMem[i] <= 32'hC0DE_0000 ^ (i * 32'h0001_0003);
            end
            dataMem[LOAD_ADDR[11:2]] <= loadValue;
            memReady   <= 1'b1;
            waitLeft   <= 0;
            storeCount <= 0;
            sawLoad    <= 1'b0;
        end else if (memRead || memWrite) begin
            if (memReady) begin
                // Only word accesses are used
                assert (memFunc3 == WORD_FUNC3)
                    else reportMismatch("memFunc3", word_t'(WORD_FUNC3), word_t'(memFunc3));
                if (memWrite) begin
                    assert (memAddr != POISON_ADDR)
                        else reportProblem("Store reached the poison address 0x3FC");
                    assert (storeCount < expAddr.size())
                        else reportProblem("More stores than the program makes");
                    assert (memAddr == expAddr[storeCount])
                        else reportMismatch($sformatf("store%0d_addr", storeCount),
                                            expAddr[storeCount], memAddr);
                    assert (memWriteData == expData[storeCount])
                        else reportMismatch($sformatf("store%0d_data", storeCount),
                                            expData[storeCount], memWriteData);
                    if (memAddr == 32'h300) begin
                        assert (sawLoad)
                            else reportProblem("Store of the loaded value came before the load");
                    end
                    dataMem[memAddr[11:2]] <= memWriteData;
                    storeCount <= storeCount + 1;
                end
                if (memRead && memAddr == LOAD_ADDR) begin
                    sawLoad <= 1'b1;
                end
                delay = int'($urandom % 4);
                memReady <= (delay == 0);
                waitLeft <= delay - 1;
            end else if (waitLeft == 0) begin
                memReady <= 1'b1;
            end else begin
                waitLeft <= waitLeft - 1;
            end
        end
    end

    // Bus stability and idle checks
    always @(posedge clk) begin
        idleCheck <= 1'b1;
        if (idleCheck && !started) begin
            assert (!endProcess && !memRead && !memWrite)
                else reportProblem("Core active before startProcess");
        end
        if (prevPending) begin
            assert (memRead == prevRead)
                else reportMismatch("holdMemRead", word_t'(prevRead), word_t'(memRead));
            assert (memWrite == prevWrite)
                else reportMismatch("holdMemWrite", word_t'(prevWrite), word_t'(memWrite));
            assert (memAddr == prevAddr)
                else reportMismatch("holdMemAddr", prevAddr, memAddr);
            assert (memWriteData == prevWriteData)
                else reportMismatch("holdMemWriteData", prevWriteData, memWriteData);
        end
        prevPending   <= !reset && (memRead || memWrite) && !memReady;
        prevRead      <= memRead;
        prevWrite     <= memWrite;
        prevAddr      <= memAddr;
        prevWriteData <= memWriteData;
    end

    task automatic waitForStores();
        int cycles;
        cycles = 0;
        while (storeCount < expAddr.size() && cycles < STORE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (storeCount < expAddr.size()) begin
            reportProblem("Timeout waiting for the expected stores");
        end
    endtask

    task automatic waitForHalt();
        int cycles;
        cycles = 0;
        while (!endProcess && cycles < HALT_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!endProcess) begin
            reportProblem("Timeout waiting for endProcess");
        end
    endtask

    task automatic checkQuietAfterHalt();
        int cycles;
        cycles = 0;
        while (cycles < QUIET_CYCLES) begin
            @(posedge clk);
            assert (endProcess)
                else reportProblem("endProcess dropped after the halt");
            assert (!memRead && !memWrite)
                else reportProblem("Memory access after the halt");
            cycles++;
        end
    endtask

    initial begin
        void'($urandom(16));
        loadValue = $urandom;
        buildExpected();

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        // Idle period before start
        repeat (10) @(posedge clk);
        startProcess <= 1'b1;
        started      <= 1'b1;
        @(posedge clk);
        startProcess <= 1'b0;

        waitForStores();
        waitForHalt();
        checkQuietAfterHalt();

        $display("No errors");
        $finish;
    end

endmodule

// File: files.f
logic/rvIsaPkg.sv
logic/coreCtrlPkg.sv
logic/dataMemBus.sv
logic/alu.sv
logic/registerFile.sv
logic/hazardUnit.sv
logic/controlUnit.sv
logic/processor.sv
logic/instructionMemory.sv
logic/cpuSystem.sv
verif/cpuSystemTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f files.f --top-module cpuSystemTb -o simv

if ./obj_dir/simv | tee /dev/stderr | grep "No errors" > /dev/null; then
    exit 0
else
    exit 1
fi

// File: program.hex
20000513
06400093
00152023
FF900113
00252223
002081B3
00352423
40118233
00452623
003272B3
00552823
0022E333
00652A23
003343B3
00752C23
00322433
00852E23
10002583
00758613
30C02023
00000693
00100713
00B00793
00E686B3
00170713
FEF71CE3
03700813
01068463
3E002E23
30D02223
0080006F
3E002E23
123458B7
31102423
00000073
00000013
00000013
